// ==== bus_pkg.sv ====
// Shared widths, data and address types, device selector enum,
// test utility register map and address map constants

package bus_pkg;

  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [DataWidth/8-1:0] be_t;

  // Devices on the bus
  typedef enum logic {
    DevRam      = 1'b0,
    DevTestUtil = 1'b1
  } bus_device_e;

  localparam int NrDevices = 2;

  // Test utility window, 1 kB at 0x20000
  localparam int    TestUtilOffW = 10;
  localparam addr_t TestUtilBase = 32'h0002_0000;
  localparam addr_t TestUtilMask = ~addr_t'((1 << TestUtilOffW) - 1);

  // Byte offset of each register inside the window
  typedef enum logic [TestUtilOffW-1:0] {
    RegHalt      = 10'h000,
    RegSignature = 10'h004,
    RegCount     = 10'h008
  } test_util_reg_e;

endpackage

// ==== bus.sv ====
// Single-host bus: address decode, combinational grant,
// response routing register and error response for unmapped addresses

`timescale 1ns/1ps

module bus #(
  parameter int RamDepth = 16384
) (
  input  logic            clk_i,
  input  logic            rst_n_i,

  // Host side
  input  logic            host_req_i,
  output logic            host_gnt_o,
  input  bus_pkg::addr_t  host_addr_i,
  input  logic            host_we_i,
  input  bus_pkg::be_t    host_be_i,
  input  bus_pkg::data_t  host_wdata_i,
  output logic            host_rvalid_o,
  output bus_pkg::data_t  host_rdata_o,
  output logic            host_err_o,

  // Device side
  output logic            ram_req_o,
  output logic            tu_req_o,
  output bus_pkg::addr_t  dev_addr_o,
  output logic            dev_we_o,
  output bus_pkg::be_t    dev_be_o,
  output bus_pkg::data_t  dev_wdata_o,
  input  logic            ram_rvalid_i,
  input  bus_pkg::data_t  ram_rdata_i,
  input  logic            tu_rvalid_i,
  input  bus_pkg::data_t  tu_rdata_i,
  input  logic            tu_err_i
);

  localparam bus_pkg::addr_t RamLimit = bus_pkg::addr_t'(RamDepth * 4);

  bus_pkg::bus_device_e dev_sel, sel_q;
  logic                 miss, miss_q;

  logic           dev_rvalid [bus_pkg::NrDevices];
  bus_pkg::data_t dev_rdata  [bus_pkg::NrDevices];
  logic           dev_err    [bus_pkg::NrDevices];

  // Address decode, RAM first
  always_comb begin
    dev_sel = bus_pkg::DevRam;
    miss    = 1'b0;
    if (host_addr_i < RamLimit) begin
      dev_sel = bus_pkg::DevRam;
    end else if ((host_addr_i & bus_pkg::TestUtilMask) == bus_pkg::TestUtilBase) begin
      dev_sel = bus_pkg::DevTestUtil;
    end else begin
      miss = 1'b1;
    end
  end

  // Every device accepts at once
  assign host_gnt_o = host_req_i;

  assign ram_req_o = host_req_i & ~miss & (dev_sel == bus_pkg::DevRam);
  assign tu_req_o  = host_req_i & ~miss & (dev_sel == bus_pkg::DevTestUtil);

  assign dev_addr_o  = host_addr_i;
  assign dev_we_o    = host_we_i;
  assign dev_be_o    = host_be_i;
  assign dev_wdata_o = host_wdata_i;

  // Remember where the granted request went
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q  <= bus_pkg::DevRam;
      miss_q <= 1'b0;
    end else begin
      miss_q <= host_req_i & miss;
      if (host_req_i) begin
        sel_q <= dev_sel;
      end
    end
  end

  assign dev_rvalid[bus_pkg::DevRam]      = ram_rvalid_i;
  assign dev_rdata[bus_pkg::DevRam]       = ram_rdata_i;
  assign dev_err[bus_pkg::DevRam]         = 1'b0;
  assign dev_rvalid[bus_pkg::DevTestUtil] = tu_rvalid_i;
  assign dev_rdata[bus_pkg::DevTestUtil]  = tu_rdata_i;
  assign dev_err[bus_pkg::DevTestUtil]    = tu_err_i;

  // Unmapped access answers itself with err and zero data
  assign host_rvalid_o = miss_q | dev_rvalid[sel_q];
  assign host_err_o    = miss_q | dev_err[sel_q];
  assign host_rdata_o  = miss_q ? '0 : dev_rdata[sel_q];

endmodule

// ==== ram_1p.sv ====
// Single-port word RAM with byte enables, response one cycle after request

`timescale 1ns/1ps

module ram_1p #(
  parameter int RamDepth = 16384
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            req_i,
  input  logic            we_i,
  input  bus_pkg::be_t    be_i,
  input  bus_pkg::addr_t  addr_i,
  input  bus_pkg::data_t  wdata_i,
  output logic            rvalid_o,
  output bus_pkg::data_t  rdata_o
);

  localparam int IdxWidth = $clog2(RamDepth);
  localparam int NrBytes  = bus_pkg::DataWidth / 8;

  bus_pkg::data_t        mem [RamDepth];
  logic [IdxWidth-1:0]   word_idx;

  assign word_idx = addr_i[IdxWidth+1:2];

  // Storage and read data
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < NrBytes; b++) begin
          if (be_i[b]) begin
            mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
        rdata_o <= '0;
      end else begin
        rdata_o <= mem[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

endmodule

// ==== test_util.sv ====
// Test utility device: halt flag, signature and write count registers,
// error response for partial writes and unused offsets

`timescale 1ns/1ps

module test_util (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            req_i,
  input  logic            we_i,
  input  bus_pkg::be_t    be_i,
  input  bus_pkg::addr_t  addr_i,
  input  bus_pkg::data_t  wdata_i,
  output logic            rvalid_o,
  output bus_pkg::data_t  rdata_o,
  output logic            err_o,
  output logic            halt_o
);

  bus_pkg::test_util_reg_e reg_sel;
  bus_pkg::data_t          rd_val;
  bus_pkg::data_t          sig_q;
  bus_pkg::data_t          cnt_q;
  logic                    acc_err;
  logic                    halt_q;

  assign reg_sel = bus_pkg::test_util_reg_e'(addr_i[bus_pkg::TestUtilOffW-1:0]);

  // Register lookup and access check
  always_comb begin
    rd_val  = '0;
    acc_err = we_i & ~(&be_i);
    case (reg_sel)
      bus_pkg::RegHalt:      rd_val = bus_pkg::data_t'(halt_q);
      bus_pkg::RegSignature: rd_val = sig_q;
      // Count is read-only, a full write is dropped
      bus_pkg::RegCount:     rd_val = cnt_q;
      default:               acc_err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_o <= 1'b0;
      err_o    <= 1'b0;
      halt_q   <= 1'b0;
      sig_q    <= '0;
      cnt_q    <= '0;
    end else begin
      rvalid_o <= req_i;
      err_o    <= req_i & acc_err;
      if (req_i && we_i && !acc_err) begin
        if (reg_sel == bus_pkg::RegHalt) begin
          halt_q <= 1'b1;
        end
        // Rotate left by one, then fold in the new word
        if (reg_sel == bus_pkg::RegSignature) begin
          sig_q <= {sig_q[bus_pkg::DataWidth-2:0], sig_q[bus_pkg::DataWidth-1]} ^ wdata_i;
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  // Zero data for writes and errors
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= (we_i || acc_err) ? '0 : rd_val;
    end
  end

  assign halt_o = halt_q;

endmodule

// ==== compliance_top.sv ====
// Top level of the compliance harness: bus, RAM and test utility

`timescale 1ns/1ps

module compliance_top #(
  parameter int RamDepth = 16384
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            host_req_i,
  output logic            host_gnt_o,
  input  bus_pkg::addr_t  host_addr_i,
  input  logic            host_we_i,
  input  bus_pkg::be_t    host_be_i,
  input  bus_pkg::data_t  host_wdata_i,
  output logic            host_rvalid_o,
  output bus_pkg::data_t  host_rdata_o,
  output logic            host_err_o,
  output logic            halt_o
);

  // Per-device request and response wires
  logic           dev_req    [bus_pkg::NrDevices];
  logic           dev_rvalid [bus_pkg::NrDevices];
  bus_pkg::data_t dev_rdata  [bus_pkg::NrDevices];
  logic           tu_err;

  // Shared request payload
  bus_pkg::addr_t dev_addr;
  logic           dev_we;
  bus_pkg::be_t   dev_be;
  bus_pkg::data_t dev_wdata;

  bus #(
    .RamDepth (RamDepth)
  ) u_bus (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .host_req_i    (host_req_i),
    .host_gnt_o    (host_gnt_o),
    .host_addr_i   (host_addr_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_wdata_i  (host_wdata_i),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .ram_req_o     (dev_req[bus_pkg::DevRam]),
    .tu_req_o      (dev_req[bus_pkg::DevTestUtil]),
    .dev_addr_o    (dev_addr),
    .dev_we_o      (dev_we),
    .dev_be_o      (dev_be),
    .dev_wdata_o   (dev_wdata),
    .ram_rvalid_i  (dev_rvalid[bus_pkg::DevRam]),
    .ram_rdata_i   (dev_rdata[bus_pkg::DevRam]),
    .tu_rvalid_i   (dev_rvalid[bus_pkg::DevTestUtil]),
    .tu_rdata_i    (dev_rdata[bus_pkg::DevTestUtil]),
    .tu_err_i      (tu_err)
  );

  ram_1p #(
    .RamDepth (RamDepth)
  ) u_ram (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (dev_req[bus_pkg::DevRam]),
    .we_i     (dev_we),
    .be_i     (dev_be),
    .addr_i   (dev_addr),
    .wdata_i  (dev_wdata),
    .rvalid_o (dev_rvalid[bus_pkg::DevRam]),
    .rdata_o  (dev_rdata[bus_pkg::DevRam])
  );

  test_util u_test_util (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (dev_req[bus_pkg::DevTestUtil]),
    .we_i     (dev_we),
    .be_i     (dev_be),
    .addr_i   (dev_addr),
    .wdata_i  (dev_wdata),
    .rvalid_o (dev_rvalid[bus_pkg::DevTestUtil]),
    .rdata_o  (dev_rdata[bus_pkg::DevTestUtil]),
    .err_o    (tu_err),
    .halt_o   (halt_o)
  );

endmodule

// ==== compliance_sva.sv ====
// Concurrent assertions on the host handshake and the halt flag

`timescale 1ns/1ps

module compliance_sva (
  input logic clk_i,
  input logic rst_n_i,
  input logic host_req_i,
  input logic host_gnt_o,
  input logic host_rvalid_o,
  input logic halt_o
);

  logic granted;

  assign granted = host_req_i & host_gnt_o;

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_gnt_o |-> host_req_i)
    else $error("gnt high without req");

  // One response per grant, exactly a cycle later
  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    granted |=> host_rvalid_o)
    else $error("no rvalid one cycle after grant");

  rvalid_needs_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_rvalid_o |-> $past(granted))
    else $error("rvalid without grant in previous cycle");

  halt_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    halt_o |=> halt_o)
    else $error("halt dropped");

endmodule

// ==== tb_compliance.sv ====
// Testbench for the compliance harness: clock, reset, LFSR stimulus,
// reference model with an expected response queue, compare tasks, report

`timescale 1ns/1ps

module tb_compliance;

  localparam int RamDepth = 1024;
  localparam int IdxWidth = $clog2(RamDepth);

  logic           clk_i = 1'b0;
  logic           rst_n_i;
  logic           host_req_i, host_gnt_o, host_we_i;
  logic           host_rvalid_o, host_err_o, halt_o;
  bus_pkg::addr_t host_addr_i;
  bus_pkg::be_t   host_be_i;
  bus_pkg::data_t host_wdata_i, host_rdata_o;

  // Reference model and expected responses in grant order
  bus_pkg::data_t ram_model [RamDepth];
  bus_pkg::data_t sig_model, cnt_model;
  logic           halt_model;
  bus_pkg::data_t exp_data_q [$];
  logic           exp_err_q [$];
  int             exp_cyc_q [$];
  string          exp_name_q [$];
  logic [15:0]    lfsr_q = 16'd30;
  int             cycle = 0;
  int             checks = 0;
  int             errors = 0;

  always #10 clk_i = ~clk_i;
  always @(posedge clk_i) cycle <= cycle + 1;

  compliance_top #(.RamDepth(RamDepth)) i_compliance_top (.*);

  bind compliance_top compliance_sva u_sva (.clk_i(clk_i), .rst_n_i(rst_n_i),
    .host_req_i(host_req_i), .host_gnt_o(host_gnt_o),
    .host_rvalid_o(host_rvalid_o), .halt_o(halt_o));

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic bus_pkg::addr_t tu_addr(logic [9:0] off);
    return bus_pkg::TestUtilBase | bus_pkg::addr_t'(off);
  endfunction

  task automatic check_data(string name, bus_pkg::data_t exp, bus_pkg::data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %0b, actual %0b", name, exp, act);
    end
  endtask

  // Model of one access as seen at grant time
  task automatic predict(bus_pkg::addr_t addr, logic we, bus_pkg::be_t be,
                         bus_pkg::data_t wdata, output bus_pkg::data_t d, output logic e);
    logic [IdxWidth-1:0] idx;
    logic [9:0]          off;
    idx = addr[IdxWidth+1:2];
    off = addr[9:0];
    d   = '0;
    e   = 1'b1;
    if (addr < RamDepth * 4) begin
      e = 1'b0;
      for (int b = 0; b < 4; b++) begin
        if (we && be[b]) begin
          ram_model[idx][8*b +: 8] = wdata[8*b +: 8];
        end
      end
      d = we ? '0 : ram_model[idx];
    end else if ((addr & bus_pkg::TestUtilMask) == bus_pkg::TestUtilBase) begin
      e = (we && be != 4'hF) ||
          !(off inside {bus_pkg::RegHalt, bus_pkg::RegSignature, bus_pkg::RegCount});
      if (!e && !we) begin
        case (off)
          bus_pkg::RegHalt:      d = bus_pkg::data_t'(halt_model);
          bus_pkg::RegSignature: d = sig_model;
          default:               d = cnt_model;
        endcase
      end else if (!e && off == bus_pkg::RegHalt) begin
        halt_model = 1'b1;
      end else if (!e && off == bus_pkg::RegSignature) begin
        sig_model = {sig_model[30:0], sig_model[31]} ^ wdata;
        cnt_model = cnt_model + 1;
      end
    end
  endtask

  // Compare any response due in this cycle
  task automatic collect_resp();
    bus_pkg::data_t d;
    logic           e;
    int             c;
    string          n;
    if (host_rvalid_o || (exp_cyc_q.size() != 0 && exp_cyc_q[0] <= cycle)) begin
      if (exp_cyc_q.size() == 0) begin
        errors++;
        $display("Response arrived with no request outstanding in cycle %0d", cycle);
      end else begin
        d = exp_data_q.pop_front();
        e = exp_err_q.pop_front();
        c = exp_cyc_q.pop_front();
        n = exp_name_q.pop_front();
        if (!host_rvalid_o || c != cycle) begin
          errors++;
          $display("Response for %s did not come one cycle after its grant", n);
        end else begin
          check_data(n, d, host_rdata_o);
          check_flag({n, " err"}, e, host_err_o);
        end
      end
    end
  endtask

  // Grant must follow the request held since the last falling edge
  task automatic check_grant();
    if (host_req_i) begin
      check_flag("grant", 1'b1, host_gnt_o);
    end else begin
      check_flag("grant idle", 1'b0, host_gnt_o);
    end
  endtask

  task automatic issue(string name, bus_pkg::addr_t addr, logic we, bus_pkg::be_t be,
                       bus_pkg::data_t wdata);
    bus_pkg::data_t d;
    logic           e;
    @(negedge clk_i);
    collect_resp();
    check_grant();
    predict(addr, we, be, wdata, d, e);
    host_req_i   = 1'b1;
    host_addr_i  = addr;
    host_we_i    = we;
    host_be_i    = be;
    host_wdata_i = wdata;
    exp_data_q.push_back(d);
    exp_err_q.push_back(e);
    exp_cyc_q.push_back(cycle + 1);
    exp_name_q.push_back(name);
  endtask

  // Idle until all responses are in
  task automatic drain();
    int t;
    t = 0;
    while (exp_cyc_q.size() != 0 && t < 20) begin
      @(negedge clk_i);
      collect_resp();
      check_grant();
      host_req_i = 1'b0;
      t++;
    end
    if (exp_cyc_q.size() != 0) begin
      errors++;
      $display("Timed out waiting for %0d outstanding responses", exp_cyc_q.size());
    end
  endtask

  task automatic read_window(string name);
    for (int i = 0; i < 32; i++) begin
      issue(name, bus_pkg::addr_t'(i * 4), 1'b0, 4'hF, '0);
    end
    drain();
  endtask

  initial begin
    bus_pkg::addr_t a;
    bus_pkg::be_t   be;
    host_req_i   = 1'b0;
    host_addr_i  = '0;
    host_we_i    = 1'b0;
    host_be_i    = '0;
    host_wdata_i = '0;
    sig_model    = '0;
    cnt_model    = '0;
    halt_model   = 1'b0;
    rst_n_i      = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Fill a 32-word window, then merge random bytes into it
    for (int i = 0; i < 32; i++) begin
      issue("ram fill", bus_pkg::addr_t'(i * 4), 1'b1, 4'hF, rand_bits(32));
    end
    for (int i = 0; i < 48; i++) begin
      be = bus_pkg::be_t'(rand_bits(4));
      issue("ram merge", rand_bits(5) << 2, 1'b1, be, rand_bits(32));
    end
    read_window("ram read");

    // Just above the RAM these would alias onto the window if decoded as RAM
    for (int i = 0; i < 16; i++) begin
      a = rand_bits(1) != 0 ? 32'h0000_1000 + (rand_bits(5) << 2)
                            : 32'h8000_0000 | rand_bits(30);
      issue("unmapped", a, rand_bits(1) != 0, 4'hF, rand_bits(32));
    end
    read_window("ram after unmapped");

    for (int i = 0; i < 8; i++) begin
      issue("sig write", tu_addr(bus_pkg::RegSignature), 1'b1, 4'hF, rand_bits(32));
    end
    issue("sig read", tu_addr(bus_pkg::RegSignature), 1'b0, 4'hF, '0);
    issue("count read", tu_addr(bus_pkg::RegCount), 1'b0, 4'hF, '0);

    // Partial writes and unused offsets must not touch any register
    for (int i = 0; i < 8; i++) begin
      be = bus_pkg::be_t'(rand_bits(4));
      if (be == 4'hF) begin
        be = 4'h7;
      end
      a = tu_addr(rand_bits(1) != 0 ? bus_pkg::RegSignature : bus_pkg::RegHalt);
      issue("partial write", a, 1'b1, be, rand_bits(32));
      a = tu_addr(10'(10'h00C + (rand_bits(6) << 2)));
      issue("bad offset", a, rand_bits(1) != 0, 4'hF, rand_bits(32));
    end
    issue("sig reread", tu_addr(bus_pkg::RegSignature), 1'b0, 4'hF, '0);
    issue("count reread", tu_addr(bus_pkg::RegCount), 1'b0, 4'hF, '0);
    drain();
    check_flag("halt low", halt_model, halt_o);

    // Back-to-back requests on consecutive cycles
    for (int i = 0; i < 40; i++) begin
      case (rand_bits(2))
        0: issue("mixed ram read", rand_bits(5) << 2, 1'b0, 4'hF, '0);
        1: issue("mixed ram write", rand_bits(5) << 2, 1'b1, 4'hF, rand_bits(32));
        2: issue("mixed sig", tu_addr(bus_pkg::RegSignature), rand_bits(1) != 0, 4'hF,
                 rand_bits(32));
        default: issue("mixed unmapped", 32'h0003_0000 | rand_bits(16), 1'b0, 4'hF, '0);
      endcase
    end
    issue("mixed count", tu_addr(bus_pkg::RegCount), 1'b0, 4'hF, '0);
    read_window("ram after mixed");

    issue("halt write", tu_addr(bus_pkg::RegHalt), 1'b1, 4'hF, rand_bits(32));
    drain();
    check_flag("halt raised", halt_model, halt_o);
    for (int i = 0; i < 8; i++) begin
      issue("write after halt", rand_bits(5) << 2, 1'b1, 4'hF, rand_bits(32));
    end
    issue("halt read", tu_addr(bus_pkg::RegHalt), 1'b0, 4'hF, '0);
    read_window("ram after halt");
    check_flag("halt held", halt_model, halt_o);

    $display("Run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
bus_pkg.sv
bus.sv
ram_1p.sv
test_util.sv
compliance_top.sv
compliance_sva.sv
tb_compliance.sv

// ==== Makefile ====
# Verilator build and run of the compliance harness testbench

VERILATOR ?= verilator
TOP       ?= tb_compliance
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
